//--- source/opl_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl_fm shared sizes
// voice count, tick rate, queue depth and data widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef OPL_DEFINES_SVH
`define OPL_DEFINES_SVH

// voices per sample tick
`define OPL_NUM_VOICES 4

// clocks per sample tick
`define OPL_TICK_DIV 256

// slots per credit queue, also the producer's starting credit
`define OPL_Q_DEPTH 4

`define OPL_SAMPLE_W 16
`define OPL_PHASE_W 16

`endif

//--- source/opl_reg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map types
// write bus record and per-voice settings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package opl_reg_pkg;

    typedef struct packed {
        logic [7:0] addr;    // [7:4] field code, [3:0] voice
        logic [7:0] data;
    } reg_write_t;

    typedef struct packed {
        logic [9:0] fnum;    // phase step before block shift
        logic [2:0] block;   // left shift of fnum
        logic [1:0] ws;      // 0 saw, 1 square, 2 triangle, 3 off
        logic [2:0] tl;      // right shift of the waveform
        logic       key_on;
        logic [3:0] route;   // bit0 a, bit1 b, bit2 c, bit3 d
    } voice_regs_t;

    localparam logic [3:0] FIELD_FNUM_LO   = 4'h1;    // data = fnum[7:0]
    localparam logic [3:0] FIELD_FNUM_HI   = 4'h2;    // data[1:0] fnum[9:8], [4:2] block
    localparam logic [3:0] FIELD_WS_TL     = 4'h3;    // data[1:0] ws, [4:2] tl
    localparam logic [3:0] FIELD_KEY_ROUTE = 4'h4;    // data[3:0] route, [4] key_on

endpackage

//--- source/opl_audio_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// audio path types
// samples, queued voice samples, stereo frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "opl_defines.svh"

package opl_audio_pkg;

    typedef logic signed [`OPL_SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        sample_t sample;
        logic    last;       // final voice of this tick
    } voice_sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_frame_t;

endpackage

//--- source/register_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file
// decodes byte bus writes into per-voice settings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "opl_defines.svh"

module register_file (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             wr_en,
    input  opl_reg_pkg::reg_write_t                          wr,
    output opl_reg_pkg::voice_regs_t [`OPL_NUM_VOICES-1:0]   voice_regs
);
    localparam int VIDX_W = $clog2(`OPL_NUM_VOICES);

    logic [3:0]        field;      // upper address nibble
    logic [3:0]        voice;      // lower address nibble
    logic [VIDX_W-1:0] vidx;       // array index
    logic              voice_ok;   // voice exists

    always_comb begin
        field    = wr.addr[7:4];
        voice    = wr.addr[3:0];
        vidx     = voice[VIDX_W-1:0];
        voice_ok = (voice < `OPL_NUM_VOICES);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            voice_regs <= '0;                                    // all voices silent
        end else if (wr_en && voice_ok) begin
            case (field)
                opl_reg_pkg::FIELD_FNUM_LO: begin
                    voice_regs[vidx].fnum[7:0] <= wr.data;
                end
                opl_reg_pkg::FIELD_FNUM_HI: begin
                    voice_regs[vidx].fnum[9:8] <= wr.data[1:0];
                    voice_regs[vidx].block     <= wr.data[4:2];
                end
                opl_reg_pkg::FIELD_WS_TL: begin
                    voice_regs[vidx].ws <= wr.data[1:0];
                    voice_regs[vidx].tl <= wr.data[4:2];
                end
                opl_reg_pkg::FIELD_KEY_ROUTE: begin
                    voice_regs[vidx].route  <= wr.data[3:0];
                    voice_regs[vidx].key_on <= wr.data[4];
                end
                default: begin
                    // unknown field, write dropped
                end
            endcase
        end
    end

endmodule

//--- source/voice_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// voice generator
// sample tick, phase accumulators, waveforms,
// credit-limited push of one sample per voice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "opl_defines.svh"

module voice_gen (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  opl_reg_pkg::voice_regs_t [`OPL_NUM_VOICES-1:0] voice_regs,
    output logic                                           push,
    output opl_audio_pkg::voice_sample_t                   push_data,
    input  logic                                           credit_return
);
    localparam int NV     = `OPL_NUM_VOICES;
    localparam int PW     = `OPL_PHASE_W;
    localparam int TW     = $clog2(`OPL_TICK_DIV);
    localparam int VIDX_W = $clog2(NV);
    localparam int CW     = $clog2(`OPL_Q_DEPTH + 1);

    logic [TW-1:0]          tick_cnt;
    logic                   tick;        // one clk per sample period
    logic [PW-1:0]          phase [NV];
    logic                   busy;        // emitting a pass
    logic [VIDX_W-1:0]      vidx;        // voice being emitted
    logic [CW-1:0]          credits;     // free slots in voice_q
    opl_audio_pkg::sample_t shaped;      // waveform after level shift

    function automatic opl_audio_pkg::sample_t wave(
        input logic [1:0]    ws,
        input logic [PW-1:0] ph
    );
        logic [13:0] p;      // top 14 phase bits
        logic [12:0] fold;   // mirrored in second half
        p    = ph[PW-1 -: 14];
        fold = ph[PW-1] ? ~p[12:0] : p[12:0];
        case (ws)
            2'd0:    wave = $signed({2'b00, p}) - 16'sd8192;
            2'd1:    wave = ph[PW-1] ? -16'sd8192 : 16'sd8191;
            2'd2:    wave = $signed({2'b00, fold, 1'b0}) - 16'sd8192;
            default: wave = '0;
        endcase
    endfunction

    always_comb begin
        tick   = (tick_cnt == TW'(`OPL_TICK_DIV - 1));
        shaped = wave(voice_regs[vidx].ws, phase[vidx]) >>> voice_regs[vidx].tl;
        push   = busy && (credits != '0);                        // stall without credit
        push_data.sample = voice_regs[vidx].key_on ? shaped : '0;
        push_data.last   = (vidx == VIDX_W'(NV - 1));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < NV; v++) begin
                phase[v] <= '0;
            end
        end else begin
            for (int v = 0; v < NV; v++) begin
                if (!voice_regs[v].key_on) begin
                    phase[v] <= '0;                              // key off restarts phase
                end else if (tick && !busy) begin
                    phase[v] <= phase[v] + (PW'(voice_regs[v].fnum) << voice_regs[v].block);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            busy     <= 1'b0;
            vidx     <= '0;
            credits  <= CW'(`OPL_Q_DEPTH);
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (tick && !busy) begin                             // tick during a pass is lost
                busy <= 1'b1;
                vidx <= '0;
            end else if (push) begin
                vidx <= vidx + 1'b1;
                if (push_data.last) begin
                    busy <= 1'b0;
                end
            end
            credits <= credits - CW'(push) + CW'(credit_return);
        end
    end

endmodule

//--- source/credit_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// credit fifo
// consumer-side queue, one credit back per pop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     credit_return
);
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;    // producer credits keep this within DEPTH
    logic          do_pop;

    always_comb begin
        empty         = (count == '0);
        do_pop        = pop && !empty;
        pop_data      = mem[rd_ptr];     // show-ahead head
        credit_return = do_pop;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(do_pop);
        end
    end

endmodule

//--- source/channel_mixer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// channel mixer
// routes voices into channels a to d, folds to stereo
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "opl_defines.svh"

module channel_mixer (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  opl_reg_pkg::voice_regs_t [`OPL_NUM_VOICES-1:0] voice_regs,
    output logic                                           vq_pop,
    input  opl_audio_pkg::voice_sample_t                   vq_data,
    input  logic                                           vq_empty,
    output logic                                           push,
    output opl_audio_pkg::stereo_frame_t                   push_data,
    input  logic                                           credit_return
);
    localparam int NCH    = 4;
    localparam int VIDX_W = $clog2(`OPL_NUM_VOICES);
    localparam int CW     = $clog2(`OPL_Q_DEPTH + 1);

    opl_audio_pkg::sample_t acc [NCH];  // channels a, b, c, d
    logic [VIDX_W-1:0]      vidx;       // voice of the next popped sample
    logic [NCH-1:0]         route;
    logic                   form;       // last voice in, build frame now
    logic                   frame_pend; // frame waiting for a credit
    logic [CW-1:0]          credits;

    always_comb begin
        vq_pop = !vq_empty && !form && !frame_pend;
        route  = voice_regs[vidx].route;
        push   = frame_pend && (credits != '0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int ch = 0; ch < NCH; ch++) begin
                acc[ch] <= '0;
            end
            vidx       <= '0;
            form       <= 1'b0;
            frame_pend <= 1'b0;
            credits    <= CW'(`OPL_Q_DEPTH);
        end else begin
            form <= vq_pop && vq_data.last;
            if (vq_pop) begin
                vidx <= vq_data.last ? '0 : vidx + 1'b1;
                for (int ch = 0; ch < NCH; ch++) begin
                    if (route[ch]) begin
                        acc[ch] <= acc[ch] + vq_data.sample;
                    end
                end
            end else if (form) begin
                for (int ch = 0; ch < NCH; ch++) begin
                    acc[ch] <= '0;                               // next tick starts clean
                end
            end
            if (form) begin
                frame_pend <= 1'b1;
            end else if (push) begin
                frame_pend <= 1'b0;
            end
            credits <= credits - CW'(push) + CW'(credit_return);
        end
    end

    // halves before the sum, so no overflow
    always_ff @(posedge clk) begin
        if (form) begin
            push_data.left  <= (acc[0] >>> 1) + (acc[1] >>> 1);
            push_data.right <= (acc[2] >>> 1) + (acc[3] >>> 1);
        end
    end

endmodule

//--- source/i2s_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2s transmitter
// 64 sclk per frame, 32-bit slots, MSB first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "opl_defines.svh"

module i2s_tx (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic                         pop,
    input  opl_audio_pkg::stereo_frame_t frame,
    input  logic                         empty,
    output logic                         sclk,
    output logic                         ws,
    output logic                         sd
);
    localparam int SW       = `OPL_SAMPLE_W;
    localparam int SLOT     = 32;
    localparam int PAD      = SLOT - SW;
    localparam int FRAME_CK = 4 * SLOT;             // two clk per sclk, two slots
    localparam int NW       = $clog2(FRAME_CK);

    logic [NW-1:0]     cnt;      // [0] sclk phase, [NW-1:1] bit position
    logic [2*SLOT-1:0] sr;       // left slot then right slot

    always_comb begin
        sclk = cnt[0];
        ws   = cnt[NW-1];                           // high for positions 32..63
        sd   = sr[2*SLOT-1];
        pop  = (cnt == NW'(1));                     // rising sclk of position 0
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            sr  <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            if (pop) begin
                // left MSB lands on position 1, one sclk after ws falls
                if (empty) begin
                    sr <= '0;                        // underflow sends silence
                end else begin
                    sr <= {frame.left, {PAD{1'b0}}, frame.right, {PAD{1'b0}}};
                end
            end else if (cnt[0]) begin
                sr <= {sr[2*SLOT-2:0], 1'b0};        // advance on sclk fall
            end
        end
    end

endmodule

//--- source/opl_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl_fm top level
// register bus in, I2S out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "opl_defines.svh"

module opl_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  opl_reg_pkg::reg_write_t wr,
    output logic                    sclk,
    output logic                    ws,
    output logic                    sd
);
    opl_reg_pkg::voice_regs_t [`OPL_NUM_VOICES-1:0] voice_regs;

    logic                         vq_push;       // voice_gen to voice_q
    opl_audio_pkg::voice_sample_t vq_push_data;
    logic                         vq_pop;
    opl_audio_pkg::voice_sample_t vq_pop_data;
    logic                         vq_empty;
    logic                         vq_credit;

    logic                         fq_push;       // mixer to frame_q
    opl_audio_pkg::stereo_frame_t fq_push_data;
    logic                         fq_pop;
    opl_audio_pkg::stereo_frame_t fq_pop_data;
    logic                         fq_empty;
    logic                         fq_credit;

    register_file register_file_inst (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr(wr), .voice_regs(voice_regs)
    );

    voice_gen voice_gen_inst (
        .clk(clk), .rst_n(rst_n), .voice_regs(voice_regs),
        .push(vq_push), .push_data(vq_push_data), .credit_return(vq_credit)
    );

    credit_fifo #(
        .payload_t(opl_audio_pkg::voice_sample_t),
        .DEPTH(`OPL_Q_DEPTH)
    ) voice_q (
        .clk(clk), .rst_n(rst_n), .push(vq_push), .push_data(vq_push_data),
        .pop(vq_pop), .pop_data(vq_pop_data), .empty(vq_empty), .credit_return(vq_credit)
    );

    channel_mixer channel_mixer_inst (
        .clk(clk), .rst_n(rst_n), .voice_regs(voice_regs),
        .vq_pop(vq_pop), .vq_data(vq_pop_data), .vq_empty(vq_empty),
        .push(fq_push), .push_data(fq_push_data), .credit_return(fq_credit)
    );

    credit_fifo #(
        .payload_t(opl_audio_pkg::stereo_frame_t),
        .DEPTH(`OPL_Q_DEPTH)
    ) frame_q (
        .clk(clk), .rst_n(rst_n), .push(fq_push), .push_data(fq_push_data),
        .pop(fq_pop), .pop_data(fq_pop_data), .empty(fq_empty), .credit_return(fq_credit)
    );

    i2s_tx i2s_tx_inst (
        .clk(clk), .rst_n(rst_n), .pop(fq_pop), .frame(fq_pop_data), .empty(fq_empty),
        .sclk(sclk), .ws(ws), .sd(sd)
    );

endmodule

//--- verif/opl_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl_fm assertions
// queue credits and I2S word select timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "opl_defines.svh"

module opl_sva (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                push,
    input logic                                pop,
    input logic                                credit_return,
    input logic [$clog2(`OPL_Q_DEPTH + 1)-1:0] count,
    input logic [$clog2(`OPL_Q_DEPTH)-1:0]     wr_ptr,
    input logic [$clog2(`OPL_Q_DEPTH)-1:0]     rd_ptr,
    input logic                                sclk,
    input logic                                ws,
    input logic                                sd
);
    // producer credits keep the queue from overflowing
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count < `OPL_Q_DEPTH))
        else $error("push into a full credit queue");

    // a credit only comes back for a slot that holds data
    credit_only_on_pop: assert property (@(posedge clk) disable iff (!rst_n)
        credit_return |-> pop && ((wr_ptr != rd_ptr) || (count == `OPL_Q_DEPTH)))
        else $error("credit returned without a pop of a filled slot");

    // ws toggles with the sclk fall, sd then sits in slot padding
    ws_on_sclk_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(ws) |-> $fell(sclk) && !sd)
        else $error("ws changed away from a falling sclk or outside padding");

endmodule

bind credit_fifo opl_sva opl_sva_q (
    .clk(clk), .rst_n(rst_n), .push(push), .pop(pop), .credit_return(credit_return),
    .count(count), .wr_ptr(wr_ptr), .rd_ptr(rd_ptr), .sclk(1'b0), .ws(1'b0), .sd(1'b0)
);

// queue side tied off here, framing check only
bind i2s_tx opl_sva opl_sva_i2s (
    .clk(clk), .rst_n(rst_n), .push(1'b0), .pop(1'b0), .credit_return(1'b0),
    .count('0), .wr_ptr('0), .rd_ptr('0), .sclk(sclk), .ws(ws), .sd(sd)
);

//--- verif/opl_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl_fm testbench
// register writes from the stim file, I2S capture, checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module opl_tb;
    localparam longint FRAME_CLK = 128;               // 64 sclk of 2 clk each
    localparam longint CLK_NS    = 100;
    localparam string  STIM_FILE = "verif/opl_stim.txt";

    typedef struct packed {
        logic [7:0]      kind;     // W write, C levels, F frequency
        logic [8*16-1:0] name;
        int              a;        // address, or frames to wait
        int              b;        // data, expected left, or frames to capture
        int              c;        // expected right, or sign changes
    } stim_rec_t;

    logic                    clk;
    logic                    rst_n;
    logic                    wr_en;
    opl_reg_pkg::reg_write_t wr;
    logic                    sclk;
    logic                    ws;
    logic                    sd;

    stim_rec_t recs[$];
    int        err_cnt;
    int        pass_cnt;
    int        fail_cnt;
    longint    limit_ns;

    opl_top opl_top_inst (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr(wr), .sclk(sclk), .ws(ws), .sd(sd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic load_stim();
        int           fd;
        string        line;
        logic [127:0] nm;
        int           a;
        int           b;
        int           c;
        logic         ok;
        stim_rec_t    rec;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            err_cnt++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;                                       // comment or blank
            end
            rec      = '0;
            rec.kind = line.getc(0);
            case (rec.kind)
                "W":     ok = ($sscanf(line, "W %h %h", a, b) == 2);
                "C":     ok = ($sscanf(line, "C %s %d %d %d", nm, a, b, c) == 4);
                "F":     ok = ($sscanf(line, "F %s %d %d %d", nm, a, b, c) == 4);
                default: ok = 1'b0;
            endcase
            if (ok) begin
                rec.name = nm;
                rec.a    = a;
                rec.b    = b;
                rec.c    = c;
                recs.push_back(rec);
            end else begin
                $display("unreadable stimulus line: %s", line);
                err_cnt++;
            end
        end
        $fclose(fd);
    endtask

    // wait frames + captured frames + sync slack, then writes and reset
    function automatic longint run_limit_ns();
        longint frames;
        longint cycles;
        frames = 8;
        cycles = 64;
        foreach (recs[i]) begin
            if (recs[i].kind == "W") begin
                cycles += 8;
            end else if (recs[i].kind == "C") begin
                frames += longint'(recs[i].a) + 4;
            end else begin
                frames += longint'(recs[i].a) + longint'(recs[i].b) + 2;
            end
        end
        return (frames * FRAME_CLK + cycles) * CLK_NS;
    endfunction

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        wr_en   = 1'b1;
        wr.addr = addr;
        wr.data = data;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
        repeat ($urandom_range(3, 0)) @(posedge clk);           // idle gap
    endtask

    task automatic capture_frame(output opl_audio_pkg::stereo_frame_t fr);
        logic [63:0] bits;
        bits = '0;
        @(negedge ws);                                          // left slot begins
        for (int i = 0; i < 64; i++) begin
            @(posedge sclk);                                    // sd steady while sclk high
            bits = {bits[62:0], sd};
        end
        // slot position k lands in bits[63-k], MSB one sclk after the ws edge
        fr.left  = bits[62:47];
        fr.right = bits[30:15];
    endtask

    task automatic skip_frames(input int n);
        opl_audio_pkg::stereo_frame_t fr;
        repeat (n) capture_frame(fr);
    endtask

    task automatic report_test(input logic [127:0] name, input int errs);
        if (errs == 0) begin
            pass_cnt++;
            $display("test %0s ok", name);
        end else begin
            fail_cnt++;
            err_cnt += errs;
            $display("test %0s failed, %0d errors", name, errs);
        end
    endtask

    task automatic check_levels(input stim_rec_t rec);
        opl_audio_pkg::stereo_frame_t f0;
        opl_audio_pkg::stereo_frame_t f1;
        opl_audio_pkg::stereo_frame_t got;
        int                           errs;
        errs = 0;
        skip_frames(rec.a);
        capture_frame(f0);
        capture_frame(f1);
        // one tick per two I2S frames, the other frame underflows to zero
        got = (f0 != '0) ? f0 : f1;
        if (int'(got.left) != rec.b) begin
            $display("ERR %0s left expected %0d actual %0d", rec.name, rec.b, int'(got.left));
            errs++;
        end
        if (int'(got.right) != rec.c) begin
            $display("ERR %0s right expected %0d actual %0d", rec.name, rec.c, int'(got.right));
            errs++;
        end
        report_test(rec.name, errs);
    endtask

    task automatic check_frequency(input stim_rec_t rec);
        opl_audio_pkg::stereo_frame_t fr;
        logic                         have_sign;
        logic                         neg;
        int                           changes;
        int                           errs;
        have_sign = 1'b0;
        neg       = 1'b0;
        changes   = 0;
        errs      = 0;
        skip_frames(rec.a);
        repeat (rec.b) begin
            capture_frame(fr);
            if (fr.left != '0) begin                            // underflow frames skipped
                if (have_sign && ((fr.left < 0) != neg)) begin
                    changes++;
                end
                neg       = (fr.left < 0);
                have_sign = 1'b1;
            end
        end
        if (changes < rec.c - 1 || changes > rec.c + 1) begin
            $display("ERR %0s sign changes expected %0d actual %0d", rec.name, rec.c, changes);
            errs++;
        end
        report_test(rec.name, errs);
    endtask

    initial begin : watchdog
        wait (limit_ns != 0);
        #(limit_ns);
        $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        stim_rec_t rec;
        void'($urandom(32'hcc58_9fe9));                         // seed once
        rst_n    = 1'b0;
        wr_en    = 1'b0;
        wr       = '0;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        load_stim();
        limit_ns = run_limit_ns();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (recs[i]) begin
            rec = recs[i];
            case (rec.kind)
                "W":     bus_write(rec.a[7:0], rec.b[7:0]);
                "C":     check_levels(rec);
                default: check_frequency(rec);
            endcase
        end
        if (pass_cnt + fail_cnt == 0) begin
            $display("no tests found in the stimulus file");
            err_cnt++;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verif/opl_stim.txt
# W addr data (hex) register write; C name wait left right: settled levels after wait frames
# F name wait frames changes: sign changes of left over the captured frames
C silence 8 0 0
W 30 00
W 40 11
C saw_tl0 8 -4096 0
W 30 05
C square_tl1 8 2047 0
W 30 0e
C tri_tl3 8 -512 0
W 30 13
C off_tl4 8 0 0
W 30 01
W 31 04
W 41 16
W 32 0a
W 42 18
W 33 09
W 43 19
C routing 8 3071 -2049
W 41 00
W 42 00
W 43 00
W 10 00
W 20 0e
F frequency 8 128 8
W 20 00
W 40 00
W 40 11
W 41 16
C keyoff_setup 8 2047 -2048
W 41 06
C keyoff_v1 8 4095 0
W 40 01
C keyoff_all 8 0 0

//--- opl_fm.f
+incdir+source
source/opl_reg_pkg.sv
source/opl_audio_pkg.sv
source/register_file.sv
source/voice_gen.sv
source/credit_fifo.sv
source/channel_mixer.sv
source/i2s_tx.sv
source/opl_top.sv
verif/opl_sva.sv
verif/opl_tb.sv

//--- Makefile
TOP := opl_tb

all: run

obj_dir/V$(TOP): opl_fm.f $(wildcard source/*.sv source/*.svh verif/*.sv)
	verilator --binary --timing --assert -f opl_fm.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	verilator --lint-only --timing -f opl_fm.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
